/* core_controller.f */
hdl/ctrl_pkg.sv
hdl/ctrl_fsm.sv
hdl/operand_match.sv
hdl/hazard_unit.sv
hdl/fwd_unit.sv
hdl/core_controller.sv
dv/core_controller_assert.sv
dv/tb_core_controller.sv

/* dv/core_controller_assert.sv */
module core_controller_assert #(
  parameter int unsigned REG_ADDR_WIDTH = ctrl_pkg::REG_ADDR_W_DEFAULT
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  ctrl_pkg::ctrl_state_e     state_i,
  input  logic                      fetch_enable_i,
  input  logic                      id_ready_i,
  input  logic                      branch_taken_ex_i,
  input  logic                      ext_req_i,
  input  logic                      data_req_ex_i,
  input  ctrl_pkg::decode_info_t    decode_i,
  input  logic [REG_ADDR_WIDTH-1:0] rs_a_addr_i,
  input  logic [REG_ADDR_WIDTH-1:0] rs_b_addr_i,
  input  logic                      rega_used_i,
  input  logic                      regb_used_i,
  input  logic                      ex_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] ex_waddr_i,
  input  logic                      alu_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] alu_waddr_i,
  input  logic                      wb_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] wb_waddr_i,
  input  logic                      ctrl_busy_i,
  input  logic                      is_decoding_i,
  input  logic                      instr_req_i,
  input  ctrl_pkg::pc_ctrl_t        pc_i,
  input  ctrl_pkg::exc_ctrl_t       exc_i,
  input  logic                      halt_if_i,
  input  logic                      halt_id_i,
  input  logic                      load_stall_i,
  input  logic                      jr_stall_i,
  input  logic                      deassert_we_i,
  input  ctrl_pkg::fwd_sel_e        fwd_a_sel_i,
  input  ctrl_pkg::fwd_sel_e        fwd_b_sel_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // polled by the testbench every cycle
  int fail_count = 0;

  ////////////////////
  // reference model
  ////////////////////

  // operand matches rebuilt from the address ports
  logic ex_a;
  logic ex_b;
  logic alu_a;
  logic alu_b;
  logic wb_a;
  logic wb_b;

  assign ex_a  = ex_we_i && rega_used_i && (ex_waddr_i == rs_a_addr_i);
  assign ex_b  = ex_we_i && regb_used_i && (ex_waddr_i == rs_b_addr_i);
  assign alu_a = alu_we_i && rega_used_i && (alu_waddr_i == rs_a_addr_i);
  assign alu_b = alu_we_i && regb_used_i && (alu_waddr_i == rs_b_addr_i);
  assign wb_a  = wb_we_i && rega_used_i && (wb_waddr_i == rs_a_addr_i);
  assign wb_b  = wb_we_i && regb_used_i && (wb_waddr_i == rs_b_addr_i);

  // ALU beats WB beats register file
  ctrl_pkg::fwd_sel_e exp_fwd_a;
  ctrl_pkg::fwd_sel_e exp_fwd_b;

  assign exp_fwd_a = alu_a ? ctrl_pkg::SEL_FW_EX :
                     (wb_a ? ctrl_pkg::SEL_FW_WB : ctrl_pkg::SEL_REGFILE);
  assign exp_fwd_b = alu_b ? ctrl_pkg::SEL_FW_EX :
                     (wb_b ? ctrl_pkg::SEL_FW_WB : ctrl_pkg::SEL_REGFILE);

  logic exp_load_stall;
  logic exp_jr_stall;
  logic exp_deassert;

  assign exp_load_stall = data_req_ex_i && (ex_a || ex_b);
  assign exp_jr_stall   = (decode_i.jump_dec == ctrl_pkg::JALR) && (ex_a || alu_a || wb_a);
  assign exp_deassert   = exp_load_stall || exp_jr_stall || decode_i.illegal || !is_decoding_i;

  // pc update strobes of interest
  logic boot_set;
  logic jump_set;

  assign boot_set = pc_i.set && (pc_i.mux == ctrl_pkg::PC_BOOT);
  assign jump_set = pc_i.set && (pc_i.mux == ctrl_pkg::PC_JUMP);

  // jump issued, ID has not yet taken a new instruction
  logic jump_pending;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      jump_pending <= 1'b0;
    end else begin
      jump_pending <= (jump_pending || jump_set) && !id_ready_i;
    end
  end

  // wfi drain window, from the decoded wfi up to decode or sleep
  logic flush_hold;

  assign flush_hold = (is_decoding_i && decode_i.pipe_flush) ||
                      (state_i == ctrl_pkg::FLUSH_EX) ||
                      (state_i == ctrl_pkg::FLUSH_WB);

  logic in_decode;

  assign in_decode = (state_i == ctrl_pkg::DECODE);

  ////////////////////
  // sequencing
  ////////////////////

  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == ctrl_pkg::RESET || state_i == ctrl_pkg::SLEEP) |-> !instr_req_i && !ctrl_busy_i)
    else begin
      $error("busy or fetch request raised while idle or asleep");
      fail_count++;
    end

  boot_once: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == ctrl_pkg::RESET && fetch_enable_i) |=> boot_set ##1 !boot_set)
    else begin
      $error("boot pc load missing or longer than one cycle");
      fail_count++;
    end

  single_jump: assert property (@(posedge clk) disable iff (!rst_n)
    jump_pending |-> !jump_set)
    else begin
      $error("second jump pc set before ID accepted a new instruction");
      fail_count++;
    end

  wfi_halt: assert property (@(posedge clk) disable iff (!rst_n)
    flush_hold |-> halt_if_i && halt_id_i)
    else begin
      $error("FAIL wfi_halt: expected halt 2'b11 actual %b%b",
             $sampled(halt_if_i), $sampled(halt_id_i));
      fail_count++;
    end

  branch_pc: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && branch_taken_ex_i && !ext_req_i) |->
      pc_i.set && (pc_i.mux == ctrl_pkg::PC_BRANCH) && !is_decoding_i)
    else begin
      $error("FAIL branch_pc: expected mux %0d actual %0d",
             ctrl_pkg::PC_BRANCH, $sampled(pc_i.mux));
      fail_count++;
    end

  branch_irq: assert property (@(posedge clk) disable iff (!rst_n)
    (in_decode && branch_taken_ex_i && ext_req_i) |->
      pc_i.set && (pc_i.mux == ctrl_pkg::PC_EXCEPTION) && exc_i.ack && exc_i.save_takenbranch)
    else begin
      $error("FAIL branch_irq: expected mux %0d exc 5'b10010 actual mux %0d exc %b",
             ctrl_pkg::PC_EXCEPTION, $sampled(pc_i.mux), $sampled(exc_i));
      fail_count++;
    end

  ////////////////////
  // hazards and forwarding
  ////////////////////

  fwd_a_chk: assert property (@(posedge clk) disable iff (!rst_n)
    fwd_a_sel_i == exp_fwd_a)
    else begin
      $error("FAIL fwd_a_sel: expected %0d actual %0d", $sampled(exp_fwd_a), $sampled(fwd_a_sel_i));
      fail_count++;
    end

  fwd_b_chk: assert property (@(posedge clk) disable iff (!rst_n)
    fwd_b_sel_i == exp_fwd_b)
    else begin
      $error("FAIL fwd_b_sel: expected %0d actual %0d", $sampled(exp_fwd_b), $sampled(fwd_b_sel_i));
      fail_count++;
    end

  load_stall_chk: assert property (@(posedge clk) disable iff (!rst_n)
    load_stall_i == exp_load_stall)
    else begin
      $error("FAIL load_stall: expected %b actual %b",
             $sampled(exp_load_stall), $sampled(load_stall_i));
      fail_count++;
    end

  jr_stall_chk: assert property (@(posedge clk) disable iff (!rst_n)
    jr_stall_i == exp_jr_stall)
    else begin
      $error("FAIL jr_stall: expected %b actual %b", $sampled(exp_jr_stall), $sampled(jr_stall_i));
      fail_count++;
    end

  deassert_chk: assert property (@(posedge clk) disable iff (!rst_n)
    deassert_we_i == exp_deassert)
    else begin
      $error("FAIL deassert_we: expected %b actual %b",
             $sampled(exp_deassert), $sampled(deassert_we_i));
      fail_count++;
    end

endmodule

bind core_controller core_controller_assert #(
  .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
) u_assert (
  .clk               (clk),
  .rst_n             (rst_n),
  .state_i           (u_ctrl_fsm.state_q),
  .fetch_enable_i    (fetch_enable_i),
  .id_ready_i        (id_ready_i),
  .branch_taken_ex_i (branch_taken_ex_i),
  .ext_req_i         (ext_req_i),
  .data_req_ex_i     (data_req_ex_i),
  .decode_i          (decode_i),
  .rs_a_addr_i       (rs_a_addr_i),
  .rs_b_addr_i       (rs_b_addr_i),
  .rega_used_i       (rega_used_i),
  .regb_used_i       (regb_used_i),
  .ex_we_i           (ex_we_i),
  .ex_waddr_i        (ex_waddr_i),
  .alu_we_i          (alu_we_i),
  .alu_waddr_i       (alu_waddr_i),
  .wb_we_i           (wb_we_i),
  .wb_waddr_i        (wb_waddr_i),
  .ctrl_busy_i       (ctrl_busy_o),
  .is_decoding_i     (is_decoding_o),
  .instr_req_i       (instr_req_o),
  .pc_i              (pc_o),
  .exc_i             (exc_o),
  .halt_if_i         (halt_if_o),
  .halt_id_i         (halt_id_o),
  .load_stall_i      (load_stall_o),
  .jr_stall_i        (jr_stall_o),
  .deassert_we_i     (deassert_we_o),
  .fwd_a_sel_i       (fwd_a_sel_o),
  .fwd_b_sel_i       (fwd_b_sel_o)
);

/* dv/tb_core_controller.sv */
module tb_core_controller;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ADDR_W = 5;
  // cycles any single wait may take
  localparam int WAIT_LIMIT = 200;
  localparam int RAND_CYCLES = 300;

  // DUT observations a wait can end on
  typedef enum int {
    EV_BOOT,
    EV_JUMP,
    EV_DECODING,
    EV_ASLEEP
  } wait_ev_e;

  logic                   clk;
  logic                   rst_n;
  logic                   fetch_enable_i;
  logic                   instr_valid_i;
  logic                   id_ready_i;
  logic                   ex_valid_i;
  logic                   branch_taken_ex_i;
  logic                   exc_req_i;
  logic                   ext_req_i;
  logic                   data_req_ex_i;
  ctrl_pkg::decode_info_t decode_i;
  logic [ADDR_W-1:0]      rs_a_addr_i;
  logic [ADDR_W-1:0]      rs_b_addr_i;
  logic                   rega_used_i;
  logic                   regb_used_i;
  logic                   ex_we_i;
  logic [ADDR_W-1:0]      ex_waddr_i;
  logic                   alu_we_i;
  logic [ADDR_W-1:0]      alu_waddr_i;
  logic                   wb_we_i;
  logic [ADDR_W-1:0]      wb_waddr_i;

  logic                   ctrl_busy_o;
  logic                   is_decoding_o;
  logic                   instr_req_o;
  ctrl_pkg::pc_ctrl_t     pc_o;
  ctrl_pkg::exc_ctrl_t    exc_o;
  logic                   halt_if_o;
  logic                   halt_id_o;
  logic                   load_stall_o;
  logic                   jr_stall_o;
  logic                   deassert_we_o;
  ctrl_pkg::fwd_sel_e     fwd_a_sel_o;
  ctrl_pkg::fwd_sel_e     fwd_b_sel_o;

  int                     seed;
  logic [31:0]            r;

  core_controller #(
    .REG_ADDR_WIDTH (ADDR_W)
  ) u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .ext_req_i         (ext_req_i),
    .data_req_ex_i     (data_req_ex_i),
    .decode_i          (decode_i),
    .rs_a_addr_i       (rs_a_addr_i),
    .rs_b_addr_i       (rs_b_addr_i),
    .rega_used_i       (rega_used_i),
    .regb_used_i       (regb_used_i),
    .ex_we_i           (ex_we_i),
    .ex_waddr_i        (ex_waddr_i),
    .alu_we_i          (alu_we_i),
    .alu_waddr_i       (alu_waddr_i),
    .wb_we_i           (wb_we_i),
    .wb_waddr_i        (wb_waddr_i),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_o              (pc_o),
    .exc_o             (exc_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .load_stall_o      (load_stall_o),
    .jr_stall_o        (jr_stall_o),
    .deassert_we_o     (deassert_we_o),
    .fwd_a_sel_o       (fwd_a_sel_o),
    .fwd_b_sel_o       (fwd_b_sel_o)
  );

  ////////////////////
  // helpers
  ////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  function automatic logic ev_seen(input wait_ev_e ev);
    case (ev)
      EV_BOOT:     return pc_o.set && (pc_o.mux == ctrl_pkg::PC_BOOT);
      EV_JUMP:     return pc_o.set && (pc_o.mux == ctrl_pkg::PC_JUMP);
      EV_DECODING: return is_decoding_o;
      default:     return !ctrl_busy_o;
    endcase
  endfunction

  // observe on negedge, outputs are settled there
  task automatic wait_for_event(input wait_ev_e ev);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ev_seen(ev) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!ev_seen(ev)) begin
      abort_run($sformatf("timeout after %0d cycles waiting for %s", cycles, ev.name()));
    end
  endtask

  ////////////////////
  // clock and monitor
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // first failing assertion ends the run
  always @(negedge clk) begin
    if (u_dut.u_assert.fail_count != 0) begin
      abort_run("concurrent assertion failed");
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    seed = 32'h4ab4_764e;
    rst_n             <= 1'b0;
    fetch_enable_i    <= 1'b0;
    instr_valid_i     <= 1'b0;
    id_ready_i        <= 1'b0;
    ex_valid_i        <= 1'b0;
    branch_taken_ex_i <= 1'b0;
    exc_req_i         <= 1'b0;
    ext_req_i         <= 1'b0;
    data_req_ex_i     <= 1'b0;
    decode_i          <= '0;
    rs_a_addr_i       <= '0;
    rs_b_addr_i       <= '0;
    rega_used_i       <= 1'b0;
    regb_used_i       <= 1'b0;
    ex_we_i           <= 1'b0;
    ex_waddr_i        <= '0;
    alu_we_i          <= 1'b0;
    alu_waddr_i       <= '0;
    wb_we_i           <= 1'b0;
    wb_waddr_i        <= '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // idle in reset, then boot
    repeat (4) @(posedge clk);
    fetch_enable_i <= 1'b1;
    wait_for_event(EV_BOOT);
    // first fetch held off by ID for a few cycles
    repeat (3) @(posedge clk);
    id_ready_i    <= 1'b1;
    instr_valid_i <= 1'b1;
    wait_for_event(EV_DECODING);

    // jal while ID is busy, only one redirect allowed
    @(posedge clk);
    id_ready_i        <= 1'b0;
    decode_i.jump_dec <= ctrl_pkg::JAL;
    wait_for_event(EV_JUMP);
    repeat (3) @(posedge clk);
    id_ready_i <= 1'b1;
    @(posedge clk);
    decode_i.jump_dec <= ctrl_pkg::NONE;

    // jalr on a register the ALU is still writing
    @(posedge clk);
    id_ready_i        <= 1'b0;
    decode_i.jump_dec <= ctrl_pkg::JALR;
    rs_a_addr_i       <= 5'd3;
    rega_used_i       <= 1'b1;
    alu_we_i          <= 1'b1;
    alu_waddr_i       <= 5'd3;
    repeat (2) @(posedge clk);
    alu_we_i <= 1'b0;
    wait_for_event(EV_JUMP);
    @(posedge clk);
    id_ready_i        <= 1'b1;
    decode_i.jump_dec <= ctrl_pkg::NONE;

    // taken branch, then branch with interrupt, then interrupt on empty ID
    @(posedge clk);
    branch_taken_ex_i <= 1'b1;
    @(posedge clk);
    ext_req_i <= 1'b1;
    @(posedge clk);
    branch_taken_ex_i <= 1'b0;
    instr_valid_i     <= 1'b0;
    @(posedge clk);
    ext_req_i     <= 1'b0;
    instr_valid_i <= 1'b1;

    // eret with fetch enabled just redirects
    @(posedge clk);
    decode_i.eret <= 1'b1;
    @(posedge clk);
    decode_i.eret <= 1'b0;

    // wfi with fetch enabled drains and resumes
    @(posedge clk);
    decode_i.pipe_flush <= 1'b1;
    ex_valid_i          <= 1'b1;
    @(posedge clk);
    decode_i.pipe_flush <= 1'b0;
    wait_for_event(EV_DECODING);

    // wfi without fetch enable sleeps until woken
    @(posedge clk);
    ex_valid_i          <= 1'b0;
    fetch_enable_i      <= 1'b0;
    decode_i.pipe_flush <= 1'b1;
    @(posedge clk);
    decode_i.pipe_flush <= 1'b0;
    repeat (3) @(posedge clk);
    ex_valid_i <= 1'b1;
    wait_for_event(EV_ASLEEP);
    @(posedge clk);
    ex_valid_i <= 1'b0;
    repeat (4) @(posedge clk);
    fetch_enable_i <= 1'b1;
    wait_for_event(EV_DECODING);

    // random traffic in DECODE, narrow addresses so matches are common
    for (int i = 0; i < RAND_CYCLES; i++) begin
      @(posedge clk);
      r = $random(seed);
      rs_a_addr_i       <= {3'b000, r[1:0]};
      rs_b_addr_i       <= {3'b000, r[3:2]};
      ex_waddr_i        <= {3'b000, r[5:4]};
      alu_waddr_i       <= {3'b000, r[7:6]};
      wb_waddr_i        <= {3'b000, r[9:8]};
      rega_used_i       <= r[10];
      regb_used_i       <= r[11];
      ex_we_i           <= r[12];
      alu_we_i          <= r[13];
      wb_we_i           <= r[14];
      data_req_ex_i     <= r[15];
      decode_i.jump_dec <= ctrl_pkg::jump_kind_e'(r[17:16]);
      decode_i.illegal  <= r[18];
      instr_valid_i     <= r[19] | r[20];
      id_ready_i        <= r[21];
      branch_taken_ex_i <= r[22] & r[23];
      ext_req_i         <= r[24] & r[25];
    end

    @(posedge clk);
    decode_i          <= '0;
    branch_taken_ex_i <= 1'b0;
    ext_req_i         <= 1'b0;
    repeat (3) @(negedge clk);
    if (u_dut.u_assert.fail_count != 0) begin
      abort_run("assertion failures recorded during the run");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

/* hdl/core_controller.sv */
module core_controller #(
  parameter int unsigned REG_ADDR_WIDTH = ctrl_pkg::REG_ADDR_W_DEFAULT
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // sequencing
  input  logic                      fetch_enable_i,
  input  logic                      instr_valid_i,
  input  logic                      id_ready_i,
  input  logic                      ex_valid_i,
  input  logic                      branch_taken_ex_i,
  input  logic                      exc_req_i,
  input  logic                      ext_req_i,
  input  logic                      data_req_ex_i,
  input  ctrl_pkg::decode_info_t    decode_i,

  // source operands in ID
  input  logic [REG_ADDR_WIDTH-1:0] rs_a_addr_i,
  input  logic [REG_ADDR_WIDTH-1:0] rs_b_addr_i,
  input  logic                      rega_used_i,
  input  logic                      regb_used_i,

  // write ports further down the pipe
  input  logic                      ex_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] ex_waddr_i,
  input  logic                      alu_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] alu_waddr_i,
  input  logic                      wb_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] wb_waddr_i,

  output logic                      ctrl_busy_o,
  output logic                      is_decoding_o,
  output logic                      instr_req_o,
  output ctrl_pkg::pc_ctrl_t        pc_o,
  output ctrl_pkg::exc_ctrl_t       exc_o,
  output logic                      halt_if_o,
  output logic                      halt_id_o,

  output logic                      load_stall_o,
  output logic                      jr_stall_o,
  output logic                      deassert_we_o,
  output ctrl_pkg::fwd_sel_e        fwd_a_sel_o,
  output ctrl_pkg::fwd_sel_e        fwd_b_sel_o
);

  // gated operand matches, shared by stall and forward logic
  ctrl_pkg::reg_hit_t reg_hit;

  ////////////////////
  // sequencing FSM
  ////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .ext_req_i         (ext_req_i),
    .decode_i          (decode_i),
    .jr_stall_i        (jr_stall_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_o              (pc_o),
    .exc_o             (exc_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  ////////////////////
  // hazards
  ////////////////////

  operand_match #(
    .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
  ) u_operand_match (
    .rs_a_addr_i (rs_a_addr_i),
    .rs_b_addr_i (rs_b_addr_i),
    .rega_used_i (rega_used_i),
    .regb_used_i (regb_used_i),
    .ex_we_i     (ex_we_i),
    .ex_waddr_i  (ex_waddr_i),
    .alu_we_i    (alu_we_i),
    .alu_waddr_i (alu_waddr_i),
    .wb_we_i     (wb_we_i),
    .wb_waddr_i  (wb_waddr_i),
    .hit_o       (reg_hit)
  );

  hazard_unit u_hazard_unit (
    .hit_i         (reg_hit),
    .data_req_ex_i (data_req_ex_i),
    .jump_dec_i    (decode_i.jump_dec),
    .illegal_i     (decode_i.illegal),
    .is_decoding_i (is_decoding_o),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall_o),
    .deassert_we_o (deassert_we_o)
  );

  fwd_unit u_fwd_unit (
    .hit_i       (reg_hit),
    .fwd_a_sel_o (fwd_a_sel_o),
    .fwd_b_sel_o (fwd_b_sel_o)
  );

endmodule

/* hdl/ctrl_fsm.sv */
module ctrl_fsm (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    fetch_enable_i,
  input  logic                    instr_valid_i,
  input  logic                    id_ready_i,
  input  logic                    ex_valid_i,
  input  logic                    branch_taken_ex_i,
  input  logic                    exc_req_i,
  input  logic                    ext_req_i,

  input  ctrl_pkg::decode_info_t  decode_i,
  input  logic                    jr_stall_i,

  output logic                    ctrl_busy_o,
  output logic                    is_decoding_o,
  output logic                    instr_req_o,
  output ctrl_pkg::pc_ctrl_t      pc_o,
  output ctrl_pkg::exc_ctrl_t     exc_o,
  output logic                    halt_if_o,
  output logic                    halt_id_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;

  // set once a jump or eret has redirected fetch
  logic jump_done_q;
  logic jump_done_d;

  // unconditional jump sitting in ID
  logic is_jump;

  assign is_jump = (decode_i.jump_dec == ctrl_pkg::JAL) ||
                   (decode_i.jump_dec == ctrl_pkg::JALR);

  ////////////////////
  // next state logic
  ////////////////////

  always_comb begin
    // defaults, core running and fetching
    state_d       = state_q;
    jump_done_d   = jump_done_q;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    pc_o.set      = 1'b0;
    pc_o.mux      = ctrl_pkg::PC_BOOT;
    exc_o         = '0;

    unique case (state_q)
      // idle after reset until fetch is enabled
      ctrl_pkg::RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::BOOT_SET;
        end
      end

      // load the boot address into the fetch pc, one cycle only
      ctrl_pkg::BOOT_SET: begin
        pc_o.set = 1'b1;
        pc_o.mux = ctrl_pkg::PC_BOOT;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      // pipeline empty, wake on fetch enable or a pending exception
      ctrl_pkg::SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      ctrl_pkg::FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = ctrl_pkg::DECODE;
        end
        // exception that woke us up, save the IF pc
        if (exc_req_i) begin
          pc_o.set      = 1'b1;
          pc_o.mux      = ctrl_pkg::PC_EXCEPTION;
          exc_o.ack     = 1'b1;
          exc_o.save_if = 1'b1;
        end
      end

      ctrl_pkg::DECODE: begin
        // valid instruction and no taken branch flushing it
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (is_jump) begin
            // target known in ID, redirect once the jr hazard clears
            pc_o.mux = ctrl_pkg::PC_JUMP;
            if (!jr_stall_i && !jump_done_q) begin
              pc_o.set    = 1'b1;
              jump_done_d = 1'b1;
            end
          end else if (exc_req_i) begin
            // synchronous exception, keep the instruction out of EX
            pc_o.set      = 1'b1;
            pc_o.mux      = ctrl_pkg::PC_EXCEPTION;
            exc_o.ack     = 1'b1;
            exc_o.save_id = 1'b1;
            halt_id_o     = 1'b1;
          end

          // return from exception
          if (decode_i.eret) begin
            pc_o.mux         = ctrl_pkg::PC_ERET;
            exc_o.restore_id = 1'b1;
            if (!jump_done_q) begin
              pc_o.set    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi, or eret back into sleep, drains the pipeline
          if (decode_i.pipe_flush || (decode_i.eret && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
        end

        // nothing valid in ID, external interrupts go in here
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_o.set      = 1'b1;
          pc_o.mux      = ctrl_pkg::PC_EXCEPTION;
          exc_o.ack     = 1'b1;
          exc_o.save_if = 1'b1;
          halt_id_o     = 1'b1;
        end

        // taken branch in EX wins over everything decoded above
        if (branch_taken_ex_i) begin
          pc_o.set = 1'b1;
          pc_o.mux = ctrl_pkg::PC_BRANCH;
          // interrupt on the branch, handler returns to the branch target
          if (ext_req_i) begin
            pc_o.mux               = ctrl_pkg::PC_EXCEPTION;
            exc_o.ack              = 1'b1;
            exc_o.save_takenbranch = 1'b1;
            halt_id_o              = 1'b1;
          end
        end
      end

      // let EX finish, nops go in behind it
      ctrl_pkg::FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = ctrl_pkg::FLUSH_WB;
        end
      end

      // pipeline drained, resume or sleep
      ctrl_pkg::FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::DECODE;
        end else begin
          state_d = ctrl_pkg::SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////
  // state registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // cleared once ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

  ////////////////////
  // widths
  ////////////////////

  // default register address width, 4 selects the rv32e register file
  localparam int unsigned REG_ADDR_W_DEFAULT = 5;

  ////////////////////
  // enums
  ////////////////////

  // controller FSM states
  typedef enum logic [3:0] {
    RESET       = 4'd0,
    BOOT_SET    = 4'd1,
    SLEEP       = 4'd2,
    FIRST_FETCH = 4'd3,
    DECODE      = 4'd4,
    FLUSH_EX    = 4'd5,
    FLUSH_WB    = 4'd6
  } ctrl_state_e;

  // jump class reported by the decoder
  typedef enum logic [1:0] {
    NONE = 2'b00,
    JAL  = 2'b01,
    JALR = 2'b10,
    COND = 2'b11
  } jump_kind_e;

  // next fetch address source in IF
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // operand source select in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  ////////////////////
  // structs
  ////////////////////

  // decoder flags for the instruction in ID
  typedef struct packed {
    logic       illegal;
    logic       eret;
    logic       pipe_flush;
    jump_kind_e jump_dec;
  } decode_info_t;

  // pc update request to the prefetcher
  typedef struct packed {
    logic    set;
    pc_mux_e mux;
  } pc_ctrl_t;

  // exception controller handshake and pc save strobes
  typedef struct packed {
    logic ack;
    logic save_if;
    logic save_id;
    logic save_takenbranch;
    logic restore_id;
  } exc_ctrl_t;

  // source operand matches, already gated by write and use enables
  typedef struct packed {
    logic ex_a;
    logic ex_b;
    logic alu_a;
    logic alu_b;
    logic wb_a;
    logic wb_b;
  } reg_hit_t;

endpackage

/* hdl/fwd_unit.sv */
module fwd_unit (
  input  ctrl_pkg::reg_hit_t hit_i,

  output ctrl_pkg::fwd_sel_e fwd_a_sel_o,
  output ctrl_pkg::fwd_sel_e fwd_b_sel_o
);

  // per operand priority, ALU result is younger than WB
  function automatic ctrl_pkg::fwd_sel_e pick_src(
    input logic alu_hit,
    input logic wb_hit
  );
    ctrl_pkg::fwd_sel_e sel;
    if (alu_hit) begin
      sel = ctrl_pkg::SEL_FW_EX;
    end else if (wb_hit) begin
      sel = ctrl_pkg::SEL_FW_WB;
    end else begin
      // no match in flight, read the register file
      sel = ctrl_pkg::SEL_REGFILE;
    end
    return sel;
  endfunction

  ////////////////////
  // operand selects
  ////////////////////

  assign fwd_a_sel_o = pick_src(hit_i.alu_a, hit_i.wb_a);
  assign fwd_b_sel_o = pick_src(hit_i.alu_b, hit_i.wb_b);

endmodule

/* hdl/hazard_unit.sv */
module hazard_unit (
  input  ctrl_pkg::reg_hit_t   hit_i,
  input  logic                 data_req_ex_i,
  input  ctrl_pkg::jump_kind_e jump_dec_i,
  input  logic                 illegal_i,
  input  logic                 is_decoding_i,

  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output logic                 deassert_we_o
);

  ////////////////////
  // stalls
  ////////////////////

  // load in EX writes a register the instruction in ID reads
  assign load_stall_o = data_req_ex_i && (hit_i.ex_a || hit_i.ex_b);

  // jalr base register still in flight anywhere down the pipe,
  // the jump target is computed in ID so nothing can be forwarded
  assign jr_stall_o = (jump_dec_i == ctrl_pkg::JALR) &&
                      (hit_i.ex_a || hit_i.alu_a || hit_i.wb_a);

  ////////////////////
  // write enable kill
  ////////////////////

  // squash the register write of whatever leaves ID this cycle
  always_comb begin
    deassert_we_o = 1'b0;
    // stalled instruction is replayed, so its bubble must not write
    if (load_stall_o || jr_stall_o) begin
      deassert_we_o = 1'b1;
    end
    // illegal instructions never write back
    if (illegal_i) begin
      deassert_we_o = 1'b1;
    end
    // flushed, halted or branch-killed slot
    if (!is_decoding_i) begin
      deassert_we_o = 1'b1;
    end
  end

endmodule

/* hdl/operand_match.sv */
module operand_match #(
  parameter int unsigned REG_ADDR_WIDTH = ctrl_pkg::REG_ADDR_W_DEFAULT
) (
  input  logic [REG_ADDR_WIDTH-1:0] rs_a_addr_i,
  input  logic [REG_ADDR_WIDTH-1:0] rs_b_addr_i,
  input  logic                      rega_used_i,
  input  logic                      regb_used_i,

  // EX stage load/store writeback port
  input  logic                      ex_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] ex_waddr_i,
  // ALU result forward port
  input  logic                      alu_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] alu_waddr_i,
  // WB stage port
  input  logic                      wb_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] wb_waddr_i,

  output ctrl_pkg::reg_hit_t        hit_o
);

  // one write port against one source operand
  function automatic logic port_hit(
    input logic                      we,
    input logic [REG_ADDR_WIDTH-1:0] waddr,
    input logic                      used,
    input logic [REG_ADDR_WIDTH-1:0] raddr
  );
    return we && used && (waddr == raddr);
  endfunction

  // operand a
  assign hit_o.ex_a  = port_hit(ex_we_i, ex_waddr_i, rega_used_i, rs_a_addr_i);
  assign hit_o.alu_a = port_hit(alu_we_i, alu_waddr_i, rega_used_i, rs_a_addr_i);
  assign hit_o.wb_a  = port_hit(wb_we_i, wb_waddr_i, rega_used_i, rs_a_addr_i);

  // operand b
  assign hit_o.ex_b  = port_hit(ex_we_i, ex_waddr_i, regb_used_i, rs_b_addr_i);
  assign hit_o.alu_b = port_hit(alu_we_i, alu_waddr_i, regb_used_i, rs_b_addr_i);
  assign hit_o.wb_b  = port_hit(wb_we_i, wb_waddr_i, regb_used_i, rs_b_addr_i);

endmodule
